//--- sim.f
+incdir+rtl
rtl/gpio_bus_pkg.sv
rtl/gpio_pin_pkg.sv
rtl/gpio_regs.sv
rtl/gpio_pads.sv
rtl/gpio_host_port.sv
rtl/gpio_top.sv
tb/gpio_checker.sv
tb/gpio_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module gpio_tb -f sim.f -o gpio_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/gpio_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

//--- tb/gpio_tb.sv
/* GPIO subsystem testbench
   Drives APB and the host bundle, compares read-backs with a reference model */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_tb;
  import gpio_bus_pkg::*;
  import gpio_pin_pkg::*;

  typedef logic [`GPIO_N_PINS-1:0] pins_t;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  // Cycle estimates per test in run order
  localparam int TEST_CYCLES  = 80 + 45 + 120 + 50 + 45 + 20;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * 2 * CLK_PERIOD;

  logic        eff_clk;
  logic        rst_ni;
  logic        host_active;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  gpio_host_t  host;
  pins_t       pin_level;
  pins_t       change_count;

  gpio_drive_t model;        // Expected register contents
  logic [31:0] rng_state;
  string       cur_test;
  int          test_err_base;
  int          check_count;
  int          error_count;
  string       name_q[$];    // Pending comparisons
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  gpio_top DUT (
    .eff_clk      (eff_clk),
    .rst_ni       (rst_ni),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .host_active  (host_active),
    .host         (host),
    .pin_level    (pin_level),
    .change_count (change_count)
  );

  bind gpio_top gpio_checker u_checker (
    .eff_clk      (eff_clk),
    .rst_ni       (rst_ni),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .host_active  (host_active),
    .p2d          (p2d),
    .change_count (change_count)
  );

  initial eff_clk = 1'b0;
  always #(CLK_PERIOD / 2) eff_clk = ~eff_clk;

  // ==============================
  // Models and helpers
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] widen(input pins_t v);
    return {{(`GPIO_DW - `GPIO_N_PINS){1'b0}}, v};
  endfunction

  // Device level where oe is set, otherwise host, pull or low
  function automatic pins_t expected_pins(input gpio_drive_t d, input gpio_host_t h);
    pins_t lvl;
    for (int i = 0; i < `GPIO_N_PINS; i++) begin
      if (d.oe[i])           lvl[i] = d.out[i];
      else if (h.en[i])      lvl[i] = h.val[i];
      else if (d.pull_en[i]) lvl[i] = d.pull_sel[i];
      else                   lvl[i] = 1'b0;
    end
    return lvl;
  endfunction

  // Upper half names the bits, lower half gives their values
  function automatic pins_t masked_update(input pins_t cur, input logic [31:0] word);
    pins_t res;
    res = cur;
    for (int i = 0; i < `GPIO_N_PINS; i++) begin
      if (word[`GPIO_N_PINS + i]) res[i] = word[i];
    end
    return res;
  endfunction

  task automatic expect_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    name_q.push_back({cur_test, " ", what});
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // Comparing process drains the queue on each falling edge
  always @(negedge eff_clk) begin
    while (name_q.size() > 0) begin
      check_count++;
      if (exp_q[0] !== act_q[0]) begin
        error_count++;
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name_q[0], exp_q[0], act_q[0]);
      end
      name_q.delete(0);
      exp_q.delete(0);
      act_q.delete(0);
    end
  end

  task automatic step();
    @(posedge eff_clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = error_count;
  endtask

  task automatic finish_test();
    int errs;
    @(negedge eff_clk);
    #1;
    errs = error_count - test_err_base;
    $display("%-12s %s, %0d mismatches", cur_test, (errs == 0) ? "ok" : "mismatch", errs);
    step();
  endtask

  // ==============================
  // APB access
  // ==============================
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1; // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    step();
    apb_req.penable = 1'b1; // Access phase
    #2;
    err = apb_rsp.pslverr;
    expect_word($sformatf("pready write 0x%02h", addr), 32'd1, {31'b0, apb_rsp.pready});
    step();
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    step();
    apb_req.penable = 1'b1;
    #2;
    data = apb_rsp.prdata;  // Valid mid access phase
    err  = apb_rsp.pslverr;
    expect_word($sformatf("pready read 0x%02h", addr), 32'd1, {31'b0, apb_rsp.pready});
    step();
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    expect_word($sformatf("pslverr write 0x%02h", addr), 32'd0, {31'b0, err});
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    expect_word($sformatf("read 0x%02h", addr), exp, data);
    expect_word($sformatf("pslverr read 0x%02h", addr), 32'd0, {31'b0, err});
  endtask

  task automatic program_drive(input gpio_drive_t d);
    reg_write(`GPIO_OFS_DIRECT_OUT, widen(d.out));
    reg_write(`GPIO_OFS_DIRECT_OE, widen(d.oe));
    reg_write(`GPIO_OFS_PULL_EN, widen(d.pull_en));
    reg_write(`GPIO_OFS_PULL_SEL, widen(d.pull_sel));
  endtask

  task automatic check_drive();
    reg_check(`GPIO_OFS_DIRECT_OUT, widen(model.out));
    reg_check(`GPIO_OFS_DIRECT_OE, widen(model.oe));
    reg_check(`GPIO_OFS_PULL_EN, widen(model.pull_en));
    reg_check(`GPIO_OFS_PULL_SEL, widen(model.pull_sel));
  endtask

  task automatic check_pins(input string what, input pins_t exp);
    #2;
    expect_word(what, widen(exp), widen(pin_level));
    step();
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin : main
    logic [31:0] rnd;
    logic [31:0] data;
    logic        err;
    pins_t       toggle;
    pins_t       chg;
    pins_t       hold_pins;
    pins_t       base;
    pins_t       n_distinct;
    pins_t       nxt;
    gpio_host_t  old_host;

    rng_state   = 32'd72;
    check_count = 0;
    error_count = 0;
    apb_req     = '0;
    host        = '0;
    model       = '0;
    host_active = 1'b1;
    rst_ni      = 1'b1;
    #1;
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge eff_clk);
    #1;
    rst_ni = 1'b1;

    start_test("readback");
    reg_check(`GPIO_OFS_DATA_IN, 32'd0);
    reg_check(`GPIO_OFS_MASKED_OUT, 32'd0);
    reg_check(`GPIO_OFS_CHANGE, 32'd0);
    check_drive();
    for (int r = 0; r < 4; r++) begin
      model = {next_rand(), next_rand()};
      program_drive(model);
      check_drive();
    end
    finish_test();

    start_test("masked_out");
    for (int r = 0; r < 10; r++) begin
      rnd = next_rand();
      reg_write(`GPIO_OFS_MASKED_OUT, rnd);
      model.out = masked_update(model.out, rnd);
      reg_check(`GPIO_OFS_DIRECT_OUT, widen(model.out));
    end
    reg_check(`GPIO_OFS_MASKED_OUT, 32'd0);
    finish_test();

    start_test("pin_resolve");
    for (int r = 0; r < 8; r++) begin
      host  = next_rand();
      model = {next_rand(), next_rand()};
      program_drive(model);
      step(); // Pull value reaches p2d
      check_pins("pin_level", expected_pins(model, host));
      repeat (3) step();
      reg_check(`GPIO_OFS_DATA_IN, widen(expected_pins(model, host)));
    end
    finish_test();

    start_test("change");
    model.oe      = 16'h00FF;
    model.pull_en = 16'h0000;
    program_drive(model);
    host.en  = 16'hFF00;
    host.val = 16'h0000;
    repeat (4) step();
    reg_write(`GPIO_OFS_CHANGE, 32'h0000FFFF);
    reg_check(`GPIO_OFS_CHANGE, 32'd0);
    for (int r = 0; r < 3; r++) begin
      rnd      = next_rand();
      toggle   = (rnd[`GPIO_N_PINS-1:0] & 16'hFF00) | 16'h0100;
      old_host = host;
      host.val = host.val ^ toggle;
      chg      = expected_pins(model, host) ^ expected_pins(model, old_host);
      repeat (4) step();
      reg_check(`GPIO_OFS_CHANGE, widen(chg));
      reg_write(`GPIO_OFS_CHANGE, widen(chg));
      reg_check(`GPIO_OFS_CHANGE, 32'd0);
    end
    finish_test();

    start_test("host_agent");
    model.oe = 16'h0F0F;
    program_drive(model);
    host.en = 16'hF0F0;
    repeat (4) step();
    hold_pins   = expected_pins(model, host);
    base        = change_count;
    host_active = 1'b0;
    for (int r = 0; r < 3; r++) begin
      rnd      = next_rand();
      host.val = rnd[`GPIO_N_PINS-1:0];
      repeat (2) step();
    end
    check_pins("pin_level frozen", hold_pins);
    nxt       = model.out ^ 16'h0001; // Bit 0 is device driven
    model.out = nxt;
    reg_write(`GPIO_OFS_DIRECT_OUT, widen(nxt));
    repeat (2) step();
    expect_word("count frozen", widen(base), widen(change_count));
    host_active = 1'b1;
    step();
    n_distinct = 16'd1; // Level written while inactive
    for (int r = 0; r < 6; r++) begin
      rnd = next_rand();
      nxt = model.out ^ ((rnd[`GPIO_N_PINS-1:0] & model.oe) | 16'h0001);
      if ((nxt & model.oe) != (model.out & model.oe)) n_distinct++;
      model.out = nxt;
      reg_write(`GPIO_OFS_DIRECT_OUT, widen(nxt));
    end
    repeat (2) step();
    check_pins("pin_level active", expected_pins(model, host));
    expect_word("count", widen(base + n_distinct), widen(change_count));
    finish_test();

    start_test("bus_error");
    apb_write(8'h1C, next_rand(), err);
    expect_word("pslverr write 0x1C", 32'd1, {31'b0, err});
    apb_write(8'h05, next_rand(), err);
    expect_word("pslverr write 0x05", 32'd1, {31'b0, err});
    apb_read(8'h20, data, err);
    expect_word("pslverr read 0x20", 32'd1, {31'b0, err});
    apb_write(`GPIO_OFS_DATA_IN, next_rand(), err);
    expect_word("pslverr write DATA_IN", 32'd1, {31'b0, err});
    check_drive();
    finish_test();

    if (DUT.u_checker.assert_fails != 0) begin
      $display("Protocol checker saw %0d assertion failures", DUT.u_checker.assert_fails);
      error_count += DUT.u_checker.assert_fails;
    end
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog for a stuck run
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/gpio_checker.sv
/* GPIO protocol checker
   Assertions on the APB response, reset values and the gated host agent */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_checker (
  input logic                          eff_clk,
  input logic                          rst_ni,
  input gpio_bus_pkg::apb_req_t        apb_req,
  input gpio_bus_pkg::apb_rsp_t        apb_rsp,
  input logic                          host_active,
  input logic [`GPIO_N_PINS-1:0]       p2d,
  input logic [`GPIO_N_PINS-1:0]       change_count
);

  int assert_fails = 0; // Failure tally

  // ==============================
  // APB response
  // ==============================
  ready_in_access: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
      $error("pready high outside the access phase");
      assert_fails++;
    end

  err_with_ready: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    apb_rsp.pslverr |-> apb_rsp.pready)
    else begin
      $error("pslverr high without pready");
      assert_fails++;
    end

  // ==============================
  // Host agent
  // ==============================
  reset_clears: assert property (@(posedge eff_clk)
    !rst_ni |-> (p2d == '0 && change_count == '0))
    else begin
      $error("p2d or change_count nonzero in reset");
      assert_fails++;
    end

  // Low for a whole cycle means no host clock edge
  p2d_held: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    (!host_active && !$past(host_active)) |-> $stable(p2d))
    else begin
      $error("p2d moved while the host agent was inactive");
      assert_fails++;
    end

endmodule

`default_nettype wire

//--- rtl/gpio_top.sv
/* GPIO subsystem top
   Ties the APB register block, pad logic and host agent together */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_top (
  input  logic                     eff_clk,
  input  logic                     rst_ni,
  input  gpio_bus_pkg::apb_req_t   apb_req,
  output gpio_bus_pkg::apb_rsp_t   apb_rsp,
  input  logic                     host_active,
  input  gpio_pin_pkg::gpio_host_t host,
  output logic [`GPIO_N_PINS-1:0]  pin_level,
  output logic [`GPIO_N_PINS-1:0]  change_count
);
  import gpio_pin_pkg::*;

  gpio_drive_t             drive;
  logic [`GPIO_N_PINS-1:0] p2d;
  logic [`GPIO_N_PINS-1:0] data_in;
  logic [`GPIO_N_PINS-1:0] change_set;

  // ==============================
  // Register block
  // ==============================
  gpio_regs u_regs (
    .eff_clk    (eff_clk),
    .rst_ni     (rst_ni),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .data_in    (data_in),
    .change_set (change_set),
    .drive      (drive)
  );

  // ==============================
  // Pads and host agent
  // ==============================
  gpio_pads u_pads (
    .eff_clk    (eff_clk),
    .rst_ni     (rst_ni),
    .drive      (drive),
    .p2d        (p2d),
    .pin_level  (pin_level),
    .data_in    (data_in),
    .change_set (change_set)
  );

  gpio_host_port u_host_port (
    .eff_clk      (eff_clk),
    .rst_ni       (rst_ni),
    .active       (host_active),
    .host         (host),
    .drive        (drive),
    .pin_level    (pin_level),
    .p2d          (p2d),
    .change_count (change_count)
  );

endmodule

`default_nettype wire

//--- rtl/gpio_host_port.sv
/* GPIO host-side pin agent
   Registers the host drive on a gated clock and counts device level changes */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_host_port (
  input  logic                      eff_clk,
  input  logic                      rst_ni,
  input  logic                      active,
  input  gpio_pin_pkg::gpio_host_t  host,
  input  gpio_pin_pkg::gpio_drive_t drive,
  input  logic [`GPIO_N_PINS-1:0]   pin_level,
  output logic [`GPIO_N_PINS-1:0]   p2d,
  output logic [`GPIO_N_PINS-1:0]   change_count
);

  logic                    host_clk;
  logic [`GPIO_N_PINS-1:0] p2d_next;
  logic [`GPIO_N_PINS-1:0] d2p_level;
  logic [`GPIO_N_PINS-1:0] d2p_last_q;

  // Agent only ticks while active
  assign host_clk = eff_clk & active;

  // ==============================
  // Host to device
  // ==============================
  // Host value first, then the pull, else low
  assign p2d_next = (host.en & host.val) |
                    (~host.en & drive.pull_en & drive.pull_sel);

  always_ff @(posedge host_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      p2d <= '0;
    end else begin
      p2d <= p2d_next;
    end
  end

  // ==============================
  // Device to host
  // ==============================
  assign d2p_level = pin_level & drive.oe; // Device-driven pins only

  always_ff @(posedge host_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      d2p_last_q   <= '0;
      change_count <= '0;
    end else begin
      d2p_last_q <= d2p_level;
      if (d2p_last_q != d2p_level) begin
        change_count <= change_count + 1'b1; // Wraps at full scale
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/gpio_pads.sv
/* GPIO pad logic
   Resolves pins between device and host, then synchronizes and flags changes */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_pads (
  input  logic                      eff_clk,
  input  logic                      rst_ni,
  input  gpio_pin_pkg::gpio_drive_t drive,
  input  logic [`GPIO_N_PINS-1:0]   p2d,
  output logic [`GPIO_N_PINS-1:0]   pin_level,
  output logic [`GPIO_N_PINS-1:0]   data_in,
  output logic [`GPIO_N_PINS-1:0]   change_set
);

  logic [`GPIO_N_PINS-1:0] sync1_q;
  logic [`GPIO_N_PINS-1:0] sync2_q;

  // ==============================
  // Pin resolution
  // ==============================
  // Device driver wins where oe is set
  assign pin_level = (drive.oe & drive.out) | (~drive.oe & p2d);

  // ==============================
  // Input synchronizer
  // ==============================
  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pin_level; // First stage, may go metastable
      sync2_q <= sync1_q;   // Stable copy
    end
  end

  assign data_in = sync2_q;

  // ==============================
  // Change detection
  // ==============================
  // Flags the bits that stage two takes at the coming edge, so the
  // CHANGE register sets on the same edge that data_in updates
  assign change_set = sync1_q ^ sync2_q;

endmodule

`default_nettype wire

//--- rtl/gpio_regs.sv
/* GPIO register block
   APB slave holding output, enable, pull and sticky change registers */
`timescale 1ns/1ns
`default_nettype none

`include "gpio_cfg.svh"

module gpio_regs (
  input  logic                     eff_clk,
  input  logic                     rst_ni,
  input  gpio_bus_pkg::apb_req_t   apb_req,
  output gpio_bus_pkg::apb_rsp_t   apb_rsp,
  input  logic [`GPIO_N_PINS-1:0]  data_in,
  input  logic [`GPIO_N_PINS-1:0]  change_set,
  output gpio_pin_pkg::gpio_drive_t drive
);
  import gpio_bus_pkg::*;

  logic [`GPIO_N_PINS-1:0] out_q;
  logic [`GPIO_N_PINS-1:0] oe_q;
  logic [`GPIO_N_PINS-1:0] pull_en_q;
  logic [`GPIO_N_PINS-1:0] pull_sel_q;
  logic [`GPIO_N_PINS-1:0] change_q;
  logic [`GPIO_N_PINS-1:0] change_clr;

  logic                access;
  logic                mapped;
  logic                read_only;
  logic                wr_hit;
  logic [`GPIO_DW-1:0] rdata;
  gpio_wdata_u         wdata;

  // ==============================
  // Address decode
  // ==============================
  assign access = apb_req.psel & apb_req.penable; // Access phase only
  assign wdata  = apb_req.pwdata;

  always_comb begin
    rdata     = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (apb_req.paddr)
      `GPIO_OFS_DATA_IN: begin
        rdata[`GPIO_N_PINS-1:0] = data_in;
        read_only               = 1'b1;
      end
      `GPIO_OFS_DIRECT_OUT: rdata[`GPIO_N_PINS-1:0] = out_q;
      `GPIO_OFS_MASKED_OUT: rdata = '0; // Write only, reads zero
      `GPIO_OFS_DIRECT_OE:  rdata[`GPIO_N_PINS-1:0] = oe_q;
      `GPIO_OFS_PULL_EN:    rdata[`GPIO_N_PINS-1:0] = pull_en_q;
      `GPIO_OFS_PULL_SEL:   rdata[`GPIO_N_PINS-1:0] = pull_sel_q;
      `GPIO_OFS_CHANGE:     rdata[`GPIO_N_PINS-1:0] = change_q;
      default:              mapped = 1'b0;
    endcase
  end

  // Writes that land on a writable register
  assign wr_hit = access & apb_req.pwrite & mapped & ~read_only;

  // ==============================
  // APB response
  // ==============================
  assign apb_rsp.pready  = access; // No wait states
  assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & read_only));
  assign apb_rsp.prdata  = access ? rdata : '0;

  // ==============================
  // Control registers
  // ==============================
  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q      <= '0;
      oe_q       <= '0;
      pull_en_q  <= '0;
      pull_sel_q <= '0;
    end else if (wr_hit) begin
      case (apb_req.paddr)
        `GPIO_OFS_DIRECT_OUT: out_q <= wdata.raw[`GPIO_N_PINS-1:0];
        `GPIO_OFS_MASKED_OUT: begin
          // Only bits named by the mask move
          out_q <= (out_q & ~wdata.masked.mask) |
                   (wdata.masked.data & wdata.masked.mask);
        end
        `GPIO_OFS_DIRECT_OE:  oe_q       <= wdata.raw[`GPIO_N_PINS-1:0];
        `GPIO_OFS_PULL_EN:    pull_en_q  <= wdata.raw[`GPIO_N_PINS-1:0];
        `GPIO_OFS_PULL_SEL:   pull_sel_q <= wdata.raw[`GPIO_N_PINS-1:0];
        default: ;
      endcase
    end
  end

  // Sticky change bits, a new set wins over a clear
  assign change_clr = (wr_hit && apb_req.paddr == `GPIO_OFS_CHANGE) ?
                      wdata.raw[`GPIO_N_PINS-1:0] : '0;

  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      change_q <= '0;
    end else begin
      change_q <= (change_q & ~change_clr) | change_set;
    end
  end

  // ==============================
  // Drive bundle
  // ==============================
  assign drive.out      = out_q;
  assign drive.oe       = oe_q;
  assign drive.pull_en  = pull_en_q;
  assign drive.pull_sel = pull_sel_q;

endmodule

`default_nettype wire

//--- rtl/gpio_pin_pkg.sv
/* GPIO pin types
   Drive bundle from the registers and the outside host's request */
`default_nettype none

`include "gpio_cfg.svh"

package gpio_pin_pkg;

  // ==============================
  // Device drive bundle
  // ==============================
  typedef struct packed {
    logic [`GPIO_N_PINS-1:0] out;      // Output data
    logic [`GPIO_N_PINS-1:0] oe;       // Output enables
    logic [`GPIO_N_PINS-1:0] pull_en;  // Pull enables
    logic [`GPIO_N_PINS-1:0] pull_sel; // Pull polarity, 1 is up
  } gpio_drive_t;

  // ==============================
  // Host request bundle
  // ==============================
  typedef struct packed {
    logic [`GPIO_N_PINS-1:0] val; // Level the host drives
    logic [`GPIO_N_PINS-1:0] en;  // Per-pin host enable
  } gpio_host_t;

endpackage

`default_nettype wire

//--- rtl/gpio_bus_pkg.sv
/* GPIO bus types
   APB request/response bundles and the two views of a write word */
`default_nettype none

`include "gpio_cfg.svh"

package gpio_bus_pkg;

  // ==============================
  // APB bundles
  // ==============================
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [`GPIO_AW-1:0] paddr;
    logic [`GPIO_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`GPIO_DW-1:0] prdata;
    logic                pready;
    logic                pslverr;
  } apb_rsp_t;

  // ==============================
  // Write data decoding
  // ==============================
  typedef struct packed {
    logic [`GPIO_N_PINS-1:0] mask; // Upper half selects bits
    logic [`GPIO_N_PINS-1:0] data; // Lower half carries values
  } masked_t;

  // DIRECT_OUT takes raw, MASKED_OUT takes masked
  typedef union packed {
    logic [`GPIO_DW-1:0] raw;
    masked_t             masked;
  } gpio_wdata_u;

endpackage

`default_nettype wire

//--- rtl/gpio_cfg.svh
/* GPIO configuration
   Pin count, APB widths and register offsets shared by the packages and RTL */
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// ==============================
// Sizes
// ==============================
`define GPIO_N_PINS 16
`define GPIO_DW     32
`define GPIO_AW     8

// ==============================
// Register map
// ==============================
`define GPIO_OFS_DATA_IN    8'h00
`define GPIO_OFS_DIRECT_OUT 8'h04
`define GPIO_OFS_MASKED_OUT 8'h08
`define GPIO_OFS_DIRECT_OE  8'h0C
`define GPIO_OFS_PULL_EN    8'h10
`define GPIO_OFS_PULL_SEL   8'h14
`define GPIO_OFS_CHANGE     8'h18

`endif
